// ==== list.f ====
common/bus_pkg.sv
common/matrix_pkg.sv
logic/periph_router.sv
logic/misc_regs.sv
led_matrix/frame_buffer.sv
led_matrix/display_regs.sv
led_matrix/matrix_scan.sv
logic/panel_top.sv
tests/tb_panel.sv

// ==== Makefile ====
TOP = tb_panel

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --top-module $(TOP) -f list.f

run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "No errors"

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f list.f

clean:
	rm -rf obj_dir

// ==== tests/tb_panel.sv ====
`timescale 1ns/1ps

module tb_panel;

    localparam int NUM_COLS  = matrix_pkg::DEF_COLS;
    localparam int COL_W     = $clog2(NUM_COLS);
    localparam int NUM_BANKS = matrix_pkg::NUM_BANKS;
    // Worst column is advance, latch, rclk and a 16 cycle show
    localparam int FRAME_MAX = NUM_COLS * (2 + NUM_BANKS + (1 << matrix_pkg::BRIGHT_W));
    localparam int TIMEOUT_CYCLES = 20 * FRAME_MAX + 6000;  // Several frames plus bus traffic

    logic        clk_12mhz;
    logic        reset_i;
    logic        wb_cyc_i, wb_stb_i, wb_we_i;
    logic [11:0] wb_adr_i;
    logic [31:0] wb_dat_i;
    logic [3:0]  wb_sel_i;
    logic [31:0] wb_dat_o;
    logic        wb_ack_o;
    logic [1:0]  buttons_i;
    logic [2:0]  stat_led_o;
    logic [3:0]  row_bank_o;
    logic [7:0]  row_data_o;
    logic        row_oe_n_o, col_first_o, col_advance_o, col_rclk_o, frame_complete_o;

    // Reference models
    logic [31:0]      fb_model [NUM_COLS];
    logic [2:0]       led_model;
    logic [3:0]       bright_val;
    int               errors;
    int               cycle_count;
    int               frames_seen;
    int               col_cnt;
    int               bank_k;
    int               show_len;
    logic [COL_W-1:0] cur_col;

    panel_top #(.NUM_COLS(NUM_COLS)) dut (
        .clk_12mhz, .reset_i, .wb_cyc_i, .wb_stb_i, .wb_we_i, .wb_adr_i, .wb_dat_i,
        .wb_sel_i, .wb_dat_o, .wb_ack_o, .buttons_i, .stat_led_o, .row_bank_o,
        .row_data_o, .row_oe_n_o, .col_first_o, .col_advance_o, .col_rclk_o,
        .frame_complete_o
    );

    initial begin
        clk_12mhz = 1'b0;
        forever #50 clk_12mhz = ~clk_12mhz;
    end

    function automatic void report_mismatch(input string name, input logic [31:0] exp,
                                            input logic [31:0] act);
        errors++;
        $display("FAIL %s expected 0x%08h got 0x%08h", name, exp, act);
    endfunction

    function automatic void report_error(input string msg);
        errors++;
        $display("ERROR %s", msg);
    endfunction

    function automatic logic [11:0] make_addr(input logic [3:0] slot, input logic [7:0] offs);
        return {slot, offs};
    endfunction

    // Byte lane merge for a write with byte enables
    function automatic logic [31:0] merge_bytes(input logic [31:0] old_w,
                                                input logic [31:0] new_w,
                                                input logic [3:0]  sel);
        logic [31:0] mask;
        mask = {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
        return (old_w & ~mask) | (new_w & mask);
    endfunction

    // ---------------------------------------------------------
    // Bus master tasks start and end 10 ns after a rising edge
    // ---------------------------------------------------------
    task automatic bus_cycle(input logic we, input logic [11:0] adr, input logic [31:0] wdat,
                             input logic [3:0] sel, output logic [31:0] rdat);
        int waited;
        waited   = 0;
        wb_cyc_i = 1'b1;
        wb_stb_i = 1'b1;
        wb_we_i  = we;
        wb_adr_i = adr;
        wb_dat_i = wdat;
        wb_sel_i = sel;
        do begin
            @(posedge clk_12mhz);
            #1;
            waited++;
        end while (!wb_ack_o && waited < 16);
        assert (wb_ack_o) else report_error("no ack from bus slave");
        assert (waited == 1) else report_mismatch("wb_ack_o latency", 1, waited);
        rdat = wb_dat_o;
        #9;
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
        @(posedge clk_12mhz);  // Strobe low for one cycle
        #10;
    endtask

    task automatic bus_write(input logic [11:0] adr, input logic [31:0] wdat,
                             input logic [3:0] sel);
        logic [31:0] unused;
        bus_cycle(1'b1, adr, wdat, sel, unused);
    endtask

    task automatic read_expect(input logic [11:0] adr, input logic [31:0] exp,
                               input string name);
        logic [31:0] rdat;
        bus_cycle(1'b0, adr, 32'd0, 4'hf, rdat);
        assert (rdat == exp) else report_mismatch(name, exp, rdat);
    endtask

    task automatic step(input int n);
        repeat (n) @(posedge clk_12mhz);
        #10;
    endtask

    task automatic wait_frame();
        do begin
            @(posedge clk_12mhz);
            #1;
        end while (!frame_complete_o);
        #9;
    endtask

    // ---------------------------------------------------------
    // Scan monitor
    // ---------------------------------------------------------
    always @(posedge clk_12mhz) begin
        if (reset_i) begin
            frames_seen = 0;
            col_cnt     = 0;
            bank_k      = 0;
            show_len    = 0;
            cur_col     = '0;
        end else begin
            if (frame_complete_o) begin
                assert (col_cnt == NUM_COLS) else report_mismatch("columns per frame",
                                                                  NUM_COLS, col_cnt);
                col_cnt = 0;
                frames_seen++;
            end
            if (col_advance_o) begin
                assert (col_first_o == (col_cnt == 0))
                    else report_mismatch("col_first_o", 32'(col_cnt == 0), 32'(col_first_o));
                cur_col = COL_W'(col_cnt);
                col_cnt++;
                bank_k  = 0;
            end
            if (row_bank_o != '0) begin
                assert (32'(row_bank_o) == (32'd1 << bank_k))
                    else report_mismatch("row_bank_o", 32'd1 << bank_k, 32'(row_bank_o));
                assert (row_data_o == 8'(fb_model[cur_col] >> (8 * bank_k)))
                    else report_mismatch("row_data_o", 8'(fb_model[cur_col] >> (8 * bank_k)),
                                         32'(row_data_o));
                bank_k++;
            end
            if (col_rclk_o) begin
                assert (bank_k == NUM_BANKS) else report_mismatch("latch cycles",
                                                                  NUM_BANKS, bank_k);
            end
            if (!row_oe_n_o) begin
                show_len++;
            end else if (show_len != 0) begin
                assert (show_len == int'(bright_val) + 1)
                    else report_mismatch("show cycles", int'(bright_val) + 1, show_len);
                show_len = 0;
            end
        end
    end

    // Bus and pin protocol
    assert property (@(posedge clk_12mhz) disable iff (reset_i) wb_ack_o |=> !wb_ack_o)
        else report_error("wb_ack_o held longer than one cycle");
    assert property (@(posedge clk_12mhz) disable iff (reset_i) $rose(wb_stb_i) |=> wb_ack_o)
        else report_error("wb_ack_o missing one cycle after request");
    assert property (@(posedge clk_12mhz) disable iff (reset_i) col_first_o |-> col_advance_o)
        else report_error("col_first_o outside a column advance");
    assert property (@(posedge clk_12mhz) disable iff (reset_i)
        col_rclk_o |-> $past(row_bank_o[NUM_BANKS-1]))
        else report_error("col_rclk_o not right after the last bank latch");
    assert property (@(posedge clk_12mhz) disable iff (reset_i)
        $fell(row_oe_n_o) |-> $past(col_rclk_o))
        else report_error("rows enabled without a preceding col_rclk_o");

    always @(posedge clk_12mhz) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            report_error("timeout, run did not finish in time");
            $display("Errors found");
            $finish;
        end
    end

    // ---------------------------------------------------------
    // Stimulus
    // ---------------------------------------------------------
    initial begin
        logic [31:0]      wdat;
        logic [3:0]       sel;
        logic [COL_W-1:0] col;
        logic [3:0]       slot;
        void'($urandom(32'hc786));
        errors      = 0;
        cycle_count = 0;
        reset_i     = 1'b1;
        wb_cyc_i    = 1'b0;
        wb_stb_i    = 1'b0;
        wb_we_i     = 1'b0;
        wb_adr_i    = '0;
        wb_dat_i    = '0;
        wb_sel_i    = '0;
        buttons_i   = '0;
        led_model   = '0;
        bright_val  = '0;
        repeat (2) @(posedge clk_12mhz);
        #10;
        reset_i = 1'b0;

        // Idle levels out of reset
        assert (row_oe_n_o) else report_mismatch("row_oe_n_o", 1, 32'(row_oe_n_o));
        assert ({col_first_o, col_advance_o, col_rclk_o, frame_complete_o} == 4'b0)
            else report_mismatch("column strobes", 0,
                                 32'({col_first_o, col_advance_o, col_rclk_o, frame_complete_o}));
        assert (row_bank_o == '0) else report_mismatch("row_bank_o", 0, 32'(row_bank_o));
        assert (row_data_o == '0) else report_mismatch("row_data_o", 0, 32'(row_data_o));
        assert (stat_led_o == '0) else report_mismatch("stat_led_o", 0, 32'(stat_led_o));
        assert (!wb_ack_o) else report_mismatch("wb_ack_o", 0, 32'(wb_ack_o));
        read_expect(make_addr(bus_pkg::SLOT_MISC, 8'd0), 32'd0, "wb_dat_o LED reg");
        read_expect(make_addr(bus_pkg::SLOT_DISP_REG, 8'd0), 32'd0, "wb_dat_o control");
        read_expect(make_addr(bus_pkg::SLOT_DISP_REG, 8'd1), 32'd0, "wb_dat_o status");

        // Unmapped slots and unused offsets
        for (int i = 0; i < 4; i++) begin
            slot = 4'($urandom_range(15, 3));
            bus_write(make_addr(slot, 8'($urandom)), $urandom, 4'hf);
            read_expect(make_addr(slot, 8'($urandom)), 32'd0, "wb_dat_o unmapped");
        end
        read_expect(make_addr(bus_pkg::SLOT_MISC, 8'd5), 32'd0, "wb_dat_o misc offset 5");

        // LED register writes with sel bit 0 alternating
        for (int i = 0; i < 8; i++) begin
            wdat = $urandom;
            sel  = {3'($urandom), 1'(i)};
            bus_write(make_addr(bus_pkg::SLOT_MISC, 8'd0), wdat, sel);
            if (sel[0]) led_model = wdat[2:0];
            assert (stat_led_o == led_model)
                else report_mismatch("stat_led_o", 32'(led_model), 32'(stat_led_o));
            read_expect(make_addr(bus_pkg::SLOT_MISC, 8'd0), 32'(led_model), "wb_dat_o LED reg");
        end

        for (int i = 0; i < 4; i++) begin
            buttons_i = 2'($urandom);
            step(3);  // Through the synchronizer
            bus_write(make_addr(bus_pkg::SLOT_MISC, 8'd1), $urandom, 4'hf);  // Read only
            assert (stat_led_o == led_model)
                else report_mismatch("stat_led_o", 32'(led_model), 32'(stat_led_o));
            read_expect(make_addr(bus_pkg::SLOT_MISC, 8'd1), 32'(buttons_i), "wb_dat_o buttons");
        end

        // Frame buffer full fill then partial writes
        for (int c = 0; c < NUM_COLS; c++) begin
            wdat = $urandom;
            bus_write(make_addr(bus_pkg::SLOT_FRAME, 8'(c)), wdat, 4'hf);
            fb_model[COL_W'(c)] = wdat;
        end
        for (int i = 0; i < 40; i++) begin
            col  = COL_W'($urandom);
            wdat = $urandom;
            sel  = 4'($urandom);
            bus_write(make_addr(bus_pkg::SLOT_FRAME, 8'(col)), wdat, sel);
            fb_model[col] = merge_bytes(fb_model[col], wdat, sel);
        end
        for (int i = 0; i < 4; i++) begin
            wdat = 32'(8'($urandom_range(255, NUM_COLS)));
            bus_write(make_addr(bus_pkg::SLOT_FRAME, wdat[7:0]), $urandom, 4'hf);
            read_expect(make_addr(bus_pkg::SLOT_FRAME, wdat[7:0]), 32'd0, "wb_dat_o past frame");
        end
        for (int c = 0; c < NUM_COLS; c++) begin
            read_expect(make_addr(bus_pkg::SLOT_FRAME, 8'(c)), fb_model[COL_W'(c)],
                        "wb_dat_o frame word");
        end

        // Scanning with a random brightness
        bright_val = 4'($urandom_range(15));
        bus_write(make_addr(bus_pkg::SLOT_DISP_REG, 8'd0), {20'd0, bright_val, 7'd0, 1'b1},
                  4'b0011);
        read_expect(make_addr(bus_pkg::SLOT_DISP_REG, 8'd0), {20'd0, bright_val, 7'd0, 1'b1},
                    "wb_dat_o control");
        for (int f = 1; f <= 3; f++) begin
            wait_frame();
            read_expect(make_addr(bus_pkg::SLOT_DISP_REG, 8'd1), 32'(f), "wb_dat_o status");
            assert (frames_seen == f) else report_mismatch("frame_complete_o pulses", f,
                                                           frames_seen);
        end

        // Disable mid frame and let that frame run out
        step(100);
        bus_write(make_addr(bus_pkg::SLOT_DISP_REG, 8'd0), {20'd0, ~bright_val, 8'd0}, 4'b0001);
        wait_frame();
        repeat (60) begin
            @(posedge clk_12mhz);
            #1;
            assert (row_oe_n_o && !col_advance_o && !col_rclk_o && row_bank_o == '0)
                else report_error("scanner active after enable was cleared");
        end
        #9;
        read_expect(make_addr(bus_pkg::SLOT_DISP_REG, 8'd1), 32'd4, "wb_dat_o status");
        read_expect(make_addr(bus_pkg::SLOT_DISP_REG, 8'd0), {20'd0, bright_val, 8'd0},
                    "wb_dat_o control");
        assert (frames_seen == 4) else report_mismatch("frame_complete_o pulses", 4,
                                                       frames_seen);

        $display("Run finished: %0d errors in %0d cycles, %0d frames", errors, cycle_count,
                 frames_seen);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// ==== logic/panel_top.sv ====
`timescale 1ns/1ps

module panel_top #(
    parameter int NUM_COLS = matrix_pkg::DEF_COLS
) (
    input  logic                             clk_12mhz,
    input  logic                             reset_i,
    input  logic                             wb_cyc_i,
    input  logic                             wb_stb_i,
    input  logic                             wb_we_i,
    input  logic [bus_pkg::ADDR_W-1:0]       wb_adr_i,
    input  logic [bus_pkg::DATA_W-1:0]       wb_dat_i,
    input  logic [bus_pkg::SEL_W-1:0]        wb_sel_i,
    output logic [bus_pkg::DATA_W-1:0]       wb_dat_o,
    output logic                             wb_ack_o,
    input  logic [1:0]                       buttons_i,
    output logic [2:0]                       stat_led_o,
    output logic [matrix_pkg::NUM_BANKS-1:0] row_bank_o,
    output logic [matrix_pkg::ROW_BITS-1:0]  row_data_o,
    output logic                             row_oe_n_o,
    output logic                             col_first_o,
    output logic                             col_advance_o,
    output logic                             col_rclk_o,
    output logic                             frame_complete_o
);

    logic                              misc_stb, disp_stb, frame_stb;
    logic                              misc_ack, disp_ack, frame_ack;
    logic [bus_pkg::DATA_W-1:0]        misc_dat, disp_dat, frame_dat;
    logic                              scan_enable;
    logic [matrix_pkg::BRIGHT_W-1:0]   brightness;
    logic [$clog2(NUM_COLS)-1:0]       col_idx;
    logic [bus_pkg::DATA_W-1:0]        col_word;

    // ---------------------------------------------------------
    // Bus fabric and slaves
    // ---------------------------------------------------------
    periph_router router (
        .clk_12mhz, .reset_i, .wb_cyc_i, .wb_stb_i, .wb_adr_i,
        .misc_stb_o(misc_stb), .disp_stb_o(disp_stb), .frame_stb_o(frame_stb),
        .misc_ack_i(misc_ack), .disp_ack_i(disp_ack), .frame_ack_i(frame_ack),
        .misc_dat_i(misc_dat), .disp_dat_i(disp_dat), .frame_dat_i(frame_dat),
        .wb_ack_o, .wb_dat_o
    );

    misc_regs misc (
        .clk_12mhz, .reset_i, .stb_i(misc_stb), .we_i(wb_we_i),
        .offs_i(wb_adr_i[bus_pkg::OFFS_W-1:0]), .dat_i(wb_dat_i), .sel_i(wb_sel_i),
        .buttons_i, .dat_o(misc_dat), .ack_o(misc_ack), .stat_led_o
    );

    display_regs disp_regs (
        .clk_12mhz, .reset_i, .stb_i(disp_stb), .we_i(wb_we_i),
        .offs_i(wb_adr_i[bus_pkg::OFFS_W-1:0]), .dat_i(wb_dat_i), .sel_i(wb_sel_i),
        .frame_done_i(frame_complete_o), .dat_o(disp_dat), .ack_o(disp_ack),
        .scan_enable_o(scan_enable), .brightness_o(brightness)
    );

    frame_buffer #(.NUM_COLS(NUM_COLS)) fbuf (
        .clk_12mhz, .reset_i, .stb_i(frame_stb), .we_i(wb_we_i),
        .offs_i(wb_adr_i[bus_pkg::OFFS_W-1:0]), .dat_i(wb_dat_i), .sel_i(wb_sel_i),
        .dat_o(frame_dat), .ack_o(frame_ack), .col_idx_i(col_idx), .col_word_o(col_word)
    );

    // Panel driver
    matrix_scan #(.NUM_COLS(NUM_COLS)) scan (
        .clk_12mhz, .reset_i, .scan_enable_i(scan_enable), .brightness_i(brightness),
        .col_word_i(col_word), .col_idx_o(col_idx), .frame_done_o(frame_complete_o),
        .row_bank_o, .row_data_o, .row_oe_n_o, .col_first_o, .col_advance_o, .col_rclk_o
    );

endmodule

// ==== led_matrix/matrix_scan.sv ====
`timescale 1ns/1ps

module matrix_scan #(
    parameter int NUM_COLS = matrix_pkg::DEF_COLS
) (
    input  logic                                            clk_12mhz,
    input  logic                                            reset_i,
    input  logic                                            scan_enable_i,
    input  logic [matrix_pkg::BRIGHT_W-1:0]                 brightness_i,
    input  logic [matrix_pkg::NUM_BANKS*matrix_pkg::ROW_BITS-1:0] col_word_i,
    output logic [$clog2(NUM_COLS)-1:0]                     col_idx_o,
    output logic                                            frame_done_o,
    output logic [matrix_pkg::NUM_BANKS-1:0]                row_bank_o,
    output logic [matrix_pkg::ROW_BITS-1:0]                 row_data_o,
    output logic                                            row_oe_n_o,
    output logic                                            col_first_o,
    output logic                                            col_advance_o,
    output logic                                            col_rclk_o
);

    localparam int BANK_W = $clog2(matrix_pkg::NUM_BANKS);

    matrix_pkg::scan_state_e       state;
    logic [BANK_W-1:0]             bank;
    logic [matrix_pkg::BRIGHT_W-1:0] show_cnt;
    logic                          last_col;

    assign last_col = col_idx_o == ($clog2(NUM_COLS))'(NUM_COLS - 1);

    // ---------------------------------------------------------
    // Column/bank walk
    // ---------------------------------------------------------
    always_ff @(posedge clk_12mhz) begin
        if (reset_i) begin
            state        <= matrix_pkg::SCAN_IDLE;
            col_idx_o    <= '0;
            bank         <= '0;
            show_cnt     <= '0;
            frame_done_o <= 1'b0;
        end else begin
            frame_done_o <= 1'b0;
            case (state)
                matrix_pkg::SCAN_IDLE: begin
                    col_idx_o <= '0;
                    if (scan_enable_i) state <= matrix_pkg::SCAN_ADVANCE;
                end
                matrix_pkg::SCAN_ADVANCE: begin
                    bank  <= '0;
                    state <= matrix_pkg::SCAN_LATCH;
                end
                matrix_pkg::SCAN_LATCH: begin
                    bank <= bank + 1'b1;
                    if (bank == BANK_W'(matrix_pkg::NUM_BANKS - 1)) begin
                        state <= matrix_pkg::SCAN_RCLK;
                    end
                end
                matrix_pkg::SCAN_RCLK: begin
                    show_cnt <= brightness_i;  // Sampled once per column
                    state    <= matrix_pkg::SCAN_SHOW;
                end
                matrix_pkg::SCAN_SHOW: begin
                    show_cnt <= show_cnt - 1'b1;
                    if (show_cnt == '0) begin
                        if (!last_col) begin
                            col_idx_o <= col_idx_o + 1'b1;
                            state     <= matrix_pkg::SCAN_ADVANCE;
                        end else begin
                            // Frame boundary, enable only checked here
                            col_idx_o    <= '0;
                            frame_done_o <= 1'b1;
                            state        <= scan_enable_i ? matrix_pkg::SCAN_ADVANCE
                                                          : matrix_pkg::SCAN_IDLE;
                        end
                    end
                end
                default: state <= matrix_pkg::SCAN_IDLE;
            endcase
        end
    end

    // Pins decoded from state
    assign col_advance_o = state == matrix_pkg::SCAN_ADVANCE;
    assign col_first_o   = col_advance_o && col_idx_o == '0;
    assign col_rclk_o    = state == matrix_pkg::SCAN_RCLK;
    assign row_oe_n_o    = state != matrix_pkg::SCAN_SHOW;  // Active low
    assign row_bank_o    = (state == matrix_pkg::SCAN_LATCH) ?
                           matrix_pkg::NUM_BANKS'(1) << bank : '0;
    assign row_data_o    = (state == matrix_pkg::SCAN_LATCH) ?
                           col_word_i[matrix_pkg::ROW_BITS*bank +: matrix_pkg::ROW_BITS] : '0;

    // Rows only lit after a latch transfer
    assert property (@(posedge clk_12mhz) disable iff (reset_i)
        !row_oe_n_o |-> state == matrix_pkg::SCAN_SHOW &&
                        $past(state) inside {matrix_pkg::SCAN_RCLK, matrix_pkg::SCAN_SHOW});

    assert property (@(posedge clk_12mhz) disable iff (reset_i) $onehot0(row_bank_o));

endmodule

// ==== led_matrix/display_regs.sv ====
`timescale 1ns/1ps

module display_regs (
    input  logic                           clk_12mhz,
    input  logic                           reset_i,
    input  logic                           stb_i,
    input  logic                           we_i,
    input  logic [bus_pkg::OFFS_W-1:0]     offs_i,
    input  logic [bus_pkg::DATA_W-1:0]     dat_i,
    input  logic [bus_pkg::SEL_W-1:0]      sel_i,
    input  logic                           frame_done_i,
    output logic [bus_pkg::DATA_W-1:0]     dat_o,
    output logic                           ack_o,
    output logic                           scan_enable_o,
    output logic [matrix_pkg::BRIGHT_W-1:0] brightness_o
);

    logic [15:0] frame_cnt;
    logic        ctrl_wr;

    assign ctrl_wr = stb_i & we_i & ~ack_o & (offs_i == bus_pkg::OFFS_W'(0));

    always_ff @(posedge clk_12mhz) begin
        if (reset_i) begin
            ack_o         <= 1'b0;
            scan_enable_o <= 1'b0;
            brightness_o  <= '0;
            frame_cnt     <= '0;
        end else begin
            ack_o <= stb_i & ~ack_o;
            if (ctrl_wr && sel_i[0]) begin
                scan_enable_o <= dat_i[0];
            end
            if (ctrl_wr && sel_i[1]) begin
                brightness_o <= dat_i[8 +: matrix_pkg::BRIGHT_W];
            end
            if (frame_done_i) begin
                frame_cnt <= frame_cnt + 16'd1;  // Wraps
            end
        end
    end

    // ---------------------------------------------------------
    // Readback
    // ---------------------------------------------------------
    always_comb begin
        dat_o = '0;
        case (offs_i)
            bus_pkg::OFFS_W'(0): begin
                dat_o[0]                          = scan_enable_o;
                dat_o[8 +: matrix_pkg::BRIGHT_W]  = brightness_o;
            end
            bus_pkg::OFFS_W'(1): dat_o = bus_pkg::DATA_W'(frame_cnt);
            default: ;
        endcase
    end

endmodule

// ==== led_matrix/frame_buffer.sv ====
`timescale 1ns/1ps

module frame_buffer #(
    parameter int NUM_COLS = matrix_pkg::DEF_COLS
) (
    input  logic                        clk_12mhz,
    input  logic                        reset_i,
    input  logic                        stb_i,
    input  logic                        we_i,
    input  logic [bus_pkg::OFFS_W-1:0]  offs_i,
    input  logic [bus_pkg::DATA_W-1:0]  dat_i,
    input  logic [bus_pkg::SEL_W-1:0]   sel_i,
    output logic [bus_pkg::DATA_W-1:0]  dat_o,
    output logic                        ack_o,
    input  logic [$clog2(NUM_COLS)-1:0] col_idx_i,
    output logic [bus_pkg::DATA_W-1:0]  col_word_o
);

    localparam int COL_W = $clog2(NUM_COLS);

    logic [bus_pkg::DATA_W-1:0] mem [NUM_COLS];  // One word per column
    logic [COL_W-1:0]           bus_idx;
    logic                       in_range;

    assign bus_idx  = offs_i[COL_W-1:0];
    assign in_range = int'(offs_i) < NUM_COLS;

    always_ff @(posedge clk_12mhz) begin
        if (reset_i) begin
            ack_o <= 1'b0;
        end else begin
            ack_o <= stb_i & ~ack_o;
        end
    end

    // ---------------------------------------------------------
    // Storage, bus port and scan port
    // ---------------------------------------------------------
    always_ff @(posedge clk_12mhz) begin
        if (stb_i && we_i && !ack_o && in_range) begin
            for (int b = 0; b < bus_pkg::SEL_W; b++) begin
                if (sel_i[b]) begin
                    mem[bus_idx][8*b +: 8] <= dat_i[8*b +: 8];
                end
            end
        end
        dat_o      <= in_range ? mem[bus_idx] : '0;  // Lands with ack
        col_word_o <= mem[col_idx_i];                // Valid the cycle after
    end

endmodule

// ==== logic/misc_regs.sv ====
`timescale 1ns/1ps

module misc_regs (
    input  logic                       clk_12mhz,
    input  logic                       reset_i,
    input  logic                       stb_i,
    input  logic                       we_i,
    input  logic [bus_pkg::OFFS_W-1:0] offs_i,
    input  logic [bus_pkg::DATA_W-1:0] dat_i,
    input  logic [bus_pkg::SEL_W-1:0]  sel_i,
    input  logic [1:0]                 buttons_i,
    output logic [bus_pkg::DATA_W-1:0] dat_o,
    output logic                       ack_o,
    output logic [2:0]                 stat_led_o
);

    logic [1:0] btn_meta;
    logic [1:0] btn_sync;
    logic       wr_en;

    assign wr_en = stb_i & we_i & ~ack_o;

    always_ff @(posedge clk_12mhz) begin
        if (reset_i) begin
            ack_o      <= 1'b0;
            stat_led_o <= '0;
            btn_meta   <= '0;
            btn_sync   <= '0;
        end else begin
            ack_o    <= stb_i & ~ack_o;
            btn_meta <= buttons_i;  // Async pins
            btn_sync <= btn_meta;
            if (wr_en && offs_i == bus_pkg::OFFS_W'(0) && sel_i[0]) begin
                stat_led_o <= dat_i[2:0];
            end
        end
    end

    // Offset is held by the master until ack
    always_comb begin
        case (offs_i)
            bus_pkg::OFFS_W'(0): dat_o = bus_pkg::DATA_W'(stat_led_o);
            bus_pkg::OFFS_W'(1): dat_o = bus_pkg::DATA_W'(btn_sync);  // Read only
            default:             dat_o = '0;
        endcase
    end

endmodule

// ==== logic/periph_router.sv ====
`timescale 1ns/1ps

module periph_router (
    input  logic                       clk_12mhz,
    input  logic                       reset_i,
    input  logic                       wb_cyc_i,
    input  logic                       wb_stb_i,
    input  logic [bus_pkg::ADDR_W-1:0] wb_adr_i,
    output logic                       misc_stb_o,
    output logic                       disp_stb_o,
    output logic                       frame_stb_o,
    input  logic                       misc_ack_i,
    input  logic                       disp_ack_i,
    input  logic                       frame_ack_i,
    input  logic [bus_pkg::DATA_W-1:0] misc_dat_i,
    input  logic [bus_pkg::DATA_W-1:0] disp_dat_i,
    input  logic [bus_pkg::DATA_W-1:0] frame_dat_i,
    output logic                       wb_ack_o,
    output logic [bus_pkg::DATA_W-1:0] wb_dat_o
);

    bus_pkg::periph_slot_e slot;
    logic                  req;
    logic                  unmapped_req;
    logic                  unmapped_ack;

    assign slot = bus_pkg::periph_slot_e'(wb_adr_i[bus_pkg::ADDR_W-1 -: bus_pkg::SLOT_W]);
    assign req  = wb_cyc_i & wb_stb_i;

    // ---------------------------------------------------------
    // Strobe steering
    // ---------------------------------------------------------
    always_comb begin
        misc_stb_o   = 1'b0;
        disp_stb_o   = 1'b0;
        frame_stb_o  = 1'b0;
        unmapped_req = 1'b0;
        if (req) begin
            case (slot)
                bus_pkg::SLOT_MISC:     misc_stb_o  = 1'b1;
                bus_pkg::SLOT_DISP_REG: disp_stb_o  = 1'b1;
                bus_pkg::SLOT_FRAME:    frame_stb_o = 1'b1;
                default:                unmapped_req = 1'b1;  // Nobody home
            endcase
        end
    end

    // Stand-in slave so an unmapped access still completes
    always_ff @(posedge clk_12mhz) begin
        if (reset_i) begin
            unmapped_ack <= 1'b0;
        end else begin
            unmapped_ack <= unmapped_req & ~unmapped_ack;
        end
    end

    // ---------------------------------------------------------
    // Return path
    // ---------------------------------------------------------
    assign wb_ack_o = misc_ack_i | disp_ack_i | frame_ack_i | unmapped_ack;

    always_comb begin
        if (misc_ack_i)       wb_dat_o = misc_dat_i;
        else if (disp_ack_i)  wb_dat_o = disp_dat_i;
        else if (frame_ack_i) wb_dat_o = frame_dat_i;
        else                  wb_dat_o = '0;  // Unmapped or idle
    end

    // Only one slave may answer a given request
    assert property (@(posedge clk_12mhz) disable iff (reset_i)
        $onehot0({misc_ack_i, disp_ack_i, frame_ack_i, unmapped_ack}));

endmodule

// ==== common/matrix_pkg.sv ====
package matrix_pkg;

    // ---------------------------------------------------------
    // Panel geometry
    // ---------------------------------------------------------
    localparam int NUM_BANKS = 4;   // Row banks, latched one by one
    localparam int ROW_BITS  = 8;   // Row data bits per bank
    localparam int DEF_COLS  = 32;  // Default column count

    // Show time per column is brightness+1 cycles
    localparam int BRIGHT_W = 4;

    // Scan engine states
    typedef enum logic [2:0] {
        SCAN_IDLE,
        SCAN_ADVANCE,   // Step the column shift register
        SCAN_LATCH,     // One cycle per bank
        SCAN_RCLK,      // Transfer to column outputs
        SCAN_SHOW       // Rows enabled
    } scan_state_e;

endpackage

// ==== common/bus_pkg.sv ====
package bus_pkg;

    // ---------------------------------------------------------
    // Classic strobe/ack bus geometry
    // ---------------------------------------------------------
    localparam int DATA_W = 32;
    localparam int SEL_W  = DATA_W / 8;  // One enable per byte
    localparam int ADDR_W = 12;          // Word address
    localparam int SLOT_W = 4;           // Top address bits pick the slave
    localparam int OFFS_W = 8;           // Word offset inside a slot

    // Decoded slot field, anything else is unmapped
    typedef enum logic [SLOT_W-1:0] {
        SLOT_MISC     = 4'd0,
        SLOT_DISP_REG = 4'd1,
        SLOT_FRAME    = 4'd2
    } periph_slot_e;

endpackage
